// ==== Makefile ====
TOP := tb_uart_core
RTL := src/uart_frame_pkg.sv src/uart_path_pkg.sv src/uart_tx_arbiter.sv src/uart_fifo.sv \
       src/baud_gen.sv src/uart_tx.sv src/uart_rx.sv src/uart_core.sv

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

obj_dir/V$(TOP): uart_core.f $(RTL) verif/tb_clk_gen.sv verif/tb_uart_core.sv
	verilator --binary --timing --top-module $(TOP) -f uart_core.f

lint:
	verilator --lint-only -Wall --top-module uart_core $(RTL)

clean:
	rm -rf obj_dir

// ==== src/baud_gen.sv ====
// baud tick generator
`default_nettype none
`timescale 1ns/1ps

module baud_gen (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            en,
    input  wire uart_path_pkg::prescale_t  prescale,
    output logic                           tick
);
    import uart_path_pkg::*;

    prescale_t cnt;

    // wrap point, also catches a prescale lowered below cnt
    assign tick = en && (cnt >= prescale);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (en)
            cnt <= (cnt >= prescale) ? '0 : cnt + 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/uart_core.sv ====
// uart with shared transmit path
`default_nettype none
`timescale 1ns/1ps

module uart_core (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                en,
    input  wire uart_path_pkg::prescale_t      prescale,
    input  wire uart_frame_pkg::parity_mode_t  parity_mode,
    input  wire                                two_stop,
    input  wire                                loopback_en,
    input  wire uart_path_pkg::client_vec_t    req,
    input  wire uart_frame_pkg::uart_word_t    wdata0,
    input  wire                                wr0,
    input  wire uart_frame_pkg::uart_word_t    wdata1,
    input  wire                                wr1,
    input  wire                                rd,
    input  wire                                rx,
    output uart_path_pkg::client_vec_t         grant,
    output logic                               tx_empty,
    output logic                               tx_full,
    output uart_frame_pkg::uart_word_t         rdata,
    output logic                               rx_empty,
    output logic                               rx_full,
    output logic                               parity_error,
    output logic                               frame_error,
    output logic                               tx
);
    import uart_frame_pkg::*;

    uart_word_t arb_wdata;
    uart_word_t tx_head;
    uart_word_t rx_word;
    logic       arb_wr;
    logic       tx_done;
    logic       rx_done;
    logic       baud_tick;
    logic       rx_in;

    // receiver listens to our own tx in loopback
    assign rx_in = loopback_en ? tx : rx;

    uart_tx_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .req(req), .tx_empty(tx_empty),
        .wdata0(wdata0), .wdata1(wdata1), .wr0(wr0), .wr1(wr1),
        .grant(grant), .wdata(arb_wdata), .wr(arb_wr)
    );

    // popped by the transmitter at the end of each frame
    uart_fifo #(.DW(DATA_BITS)) tx_fifo (
        .clk(clk), .rst_n(rst_n), .wr(arb_wr), .rd(tx_done), .wdata(arb_wdata),
        .rdata(tx_head), .empty(tx_empty), .full(tx_full)
    );

    baud_gen u_baud_gen (
        .clk(clk), .rst_n(rst_n), .en(en), .prescale(prescale), .tick(baud_tick)
    );

    // any queued word starts a frame
    uart_tx u_tx (
        .clk(clk), .rst_n(rst_n), .tick(baud_tick), .start(!tx_empty), .din(tx_head),
        .parity_mode(parity_mode), .two_stop(two_stop), .tx(tx), .done(tx_done)
    );

    uart_rx u_rx (
        .clk(clk), .rst_n(rst_n), .tick(baud_tick), .rx(rx_in),
        .parity_mode(parity_mode), .two_stop(two_stop), .dout(rx_word),
        .done(rx_done), .parity_error(parity_error), .frame_error(frame_error)
    );

    // full rx fifo silently drops new words
    uart_fifo #(.DW(DATA_BITS)) rx_fifo (
        .clk(clk), .rst_n(rst_n), .wr(rx_done), .rd(rd), .wdata(rx_word),
        .rdata(rdata), .empty(rx_empty), .full(rx_full)
    );

endmodule

`default_nettype wire

// ==== src/uart_fifo.sv ====
// first-word-fall-through fifo
`default_nettype none
`timescale 1ns/1ps

module uart_fifo #(
    parameter int DW = 8
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           wr,
    input  wire           rd,
    input  wire [DW-1:0]  wdata,
    output logic [DW-1:0] rdata,
    output logic          empty,
    output logic          full
);
    import uart_path_pkg::*;

    localparam int DEPTH = 2**FIFO_AW;

    logic [DW-1:0] mem [DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_ptr_t wr_ptr_inc;
    fifo_ptr_t rd_ptr_inc;
    logic      do_wr;
    logic      do_rd;

    // full drops writes, empty drops reads
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign wr_ptr_inc = wr_ptr + 1'b1;
    assign rd_ptr_inc = rd_ptr + 1'b1;

    // head word always on the read side
    assign rdata = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            case ({do_wr, do_rd})
                2'b10: begin
                    wr_ptr <= wr_ptr_inc;
                    empty  <= 1'b0;
                    // caught up with the reader
                    full   <= (wr_ptr_inc == rd_ptr);
                end
                2'b01: begin
                    rd_ptr <= rd_ptr_inc;
                    full   <= 1'b0;
                    empty  <= (rd_ptr_inc == wr_ptr);
                end
                // neither empty nor full here, occupancy unchanged
                2'b11: begin
                    wr_ptr <= wr_ptr_inc;
                    rd_ptr <= rd_ptr_inc;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_frame_pkg.sv ====
// uart frame format definitions
`default_nettype none

package uart_frame_pkg;

    // fixed data word, no programmable size
    localparam int DATA_BITS = 8;

    // baud ticks per serial bit
    localparam int SAMPLES = 8;

    typedef logic [DATA_BITS-1:0] uart_word_t;

    // run-time parity selection
    typedef enum logic [1:0] {
        PARITY_NONE = 2'b00,
        PARITY_ODD  = 2'b01,
        PARITY_EVEN = 2'b10
    } parity_mode_t;

    // tick position inside one bit
    typedef logic [$clog2(SAMPLES+1)-1:0] sample_cnt_t;

    // index of the data bit in flight
    typedef logic [3:0] bit_cnt_t;

endpackage

`default_nettype wire

// ==== src/uart_path_pkg.sv ====
// uart buffering and pacing definitions
`default_nettype none

package uart_path_pkg;

    // fifo address width, depth is 2**FIFO_AW
    localparam int FIFO_AW = 4;

    // read and write pointers wrap at the depth
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;

    // baud divider, tick every prescale+1 clocks
    typedef logic [15:0] prescale_t;

    // one bit per transmit client, req and grant
    typedef logic [1:0] client_vec_t;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
// uart deserializer
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                tick,
    input  wire                                rx,
    input  wire uart_frame_pkg::parity_mode_t  parity_mode,
    input  wire                                two_stop,
    output uart_frame_pkg::uart_word_t         dout,
    output logic                               done,
    output logic                               parity_error,
    output logic                               frame_error
);
    import uart_frame_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP0,
        RX_STOP1
    } rx_state_t;

    rx_state_t   state;
    rx_state_t   state_next;
    sample_cnt_t smp;
    sample_cnt_t smp_next;
    bit_cnt_t    nbit;
    bit_cnt_t    nbit_next;
    logic        rx_meta;
    logic        rx_s;
    logic        half_end;
    logic        bit_end;
    logic        par_exp;
    logic        par_flag;
    logic        stop_flag;

    // middle of the start bit, then middle of each later bit
    assign half_end = tick && (smp == sample_cnt_t'(SAMPLES/2 - 1));
    assign bit_end  = tick && (smp == sample_cnt_t'(SAMPLES - 1));

    // expected parity over the word just shifted in
    assign par_exp = (^dout) ^ (parity_mode == PARITY_ODD);

    always_comb begin
        state_next = state;
        smp_next   = smp;
        nbit_next  = nbit;
        done       = 1'b0;
        if (state != RX_IDLE && tick)
            smp_next = (half_end && state == RX_START) || bit_end ? '0 : smp + 1'b1;
        case (state)
            RX_IDLE: begin
                smp_next = '0;
                if (tick && !rx_s)
                    state_next = RX_START;
            end
            // line back high at half a bit, treat as noise
            RX_START: begin
                if (half_end) begin
                    state_next = rx_s ? RX_IDLE : RX_DATA;
                    nbit_next  = '0;
                end
            end
            RX_DATA: begin
                if (bit_end) begin
                    if (nbit == bit_cnt_t'(DATA_BITS - 1))
                        state_next = (parity_mode == PARITY_NONE) ? RX_STOP0 : RX_PARITY;
                    else
                        nbit_next = nbit + 1'b1;
                end
            end
            RX_PARITY: if (bit_end) state_next = RX_STOP0;
            RX_STOP0: begin
                if (bit_end) begin
                    state_next = two_stop ? RX_STOP1 : RX_IDLE;
                    done       = !two_stop;
                end
            end
            RX_STOP1: begin
                if (bit_end) begin
                    state_next = RX_IDLE;
                    done       = 1'b1;
                end
            end
            default: state_next = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // sync chain starts at the idle level
            rx_meta   <= 1'b1;
            rx_s      <= 1'b1;
            state     <= RX_IDLE;
            smp       <= '0;
            nbit      <= '0;
            par_flag  <= 1'b0;
            stop_flag <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            state   <= state_next;
            smp     <= smp_next;
            nbit    <= nbit_next;
            if (state == RX_IDLE) begin
                par_flag  <= 1'b0;
                stop_flag <= 1'b0;
            end else if (bit_end && state == RX_PARITY) begin
                par_flag <= rx_s ^ par_exp;
            end else if (bit_end && state == RX_STOP0) begin
                // first of two stop bits
                stop_flag <= !rx_s;
            end
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end)
            dout <= {rx_s, dout[DATA_BITS-1:1]};
    end

    // error pulses line up with done
    assign parity_error = done && par_flag;
    assign frame_error  = done && (stop_flag || !rx_s);

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// uart serializer
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                tick,
    input  wire                                start,
    input  wire uart_frame_pkg::uart_word_t    din,
    input  wire uart_frame_pkg::parity_mode_t  parity_mode,
    input  wire                                two_stop,
    output logic                               tx,
    output logic                               done
);
    import uart_frame_pkg::*;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP0,
        TX_STOP1
    } tx_state_t;

    tx_state_t   state;
    tx_state_t   state_next;
    sample_cnt_t smp;
    sample_cnt_t smp_next;
    bit_cnt_t    nbit;
    bit_cnt_t    nbit_next;
    uart_word_t  shift;
    logic        par_bit;
    logic        tx_next;
    logic        load;
    logic        bit_end;

    // last tick of the current bit
    assign bit_end = tick && (smp == sample_cnt_t'(SAMPLES - 1));
    assign load    = (state == TX_IDLE) && start;

    always_comb begin
        state_next = state;
        smp_next   = smp;
        nbit_next  = nbit;
        tx_next    = 1'b1;
        done       = 1'b0;
        if (state != TX_IDLE && tick)
            smp_next = bit_end ? '0 : smp + 1'b1;
        case (state)
            TX_IDLE: begin
                smp_next = '0;
                if (start)
                    state_next = TX_START;
            end
            // start bit, full bit time like the rest
            TX_START: begin
                tx_next = 1'b0;
                if (bit_end) begin
                    state_next = TX_DATA;
                    nbit_next  = '0;
                end
            end
            // lsb first
            TX_DATA: begin
                tx_next = shift[0];
                if (bit_end) begin
                    if (nbit == bit_cnt_t'(DATA_BITS - 1))
                        state_next = (parity_mode == PARITY_NONE) ? TX_STOP0 : TX_PARITY;
                    else
                        nbit_next = nbit + 1'b1;
                end
            end
            TX_PARITY: begin
                tx_next = par_bit;
                if (bit_end) state_next = TX_STOP0;
            end
            TX_STOP0: begin
                if (bit_end) begin
                    state_next = two_stop ? TX_STOP1 : TX_IDLE;
                    done       = !two_stop;
                end
            end
            TX_STOP1: begin
                if (bit_end) begin
                    state_next = TX_IDLE;
                    done       = 1'b1;
                end
            end
            default: state_next = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TX_IDLE;
            smp   <= '0;
            nbit  <= '0;
            // line idles high
            tx    <= 1'b1;
        end else begin
            state <= state_next;
            smp   <= smp_next;
            nbit  <= nbit_next;
            tx    <= tx_next;
        end
    end

    // word and its parity captured at load, then shifted out
    always_ff @(posedge clk) begin
        if (load) begin
            shift   <= din;
            par_bit <= (^din) ^ (parity_mode == PARITY_ODD);
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_tx_arbiter.sv ====
// transmit path arbiter
`default_nettype none
`timescale 1ns/1ps

module uart_tx_arbiter (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire uart_path_pkg::client_vec_t  req,
    input  wire                              tx_empty,
    input  wire uart_frame_pkg::uart_word_t  wdata0,
    input  wire uart_frame_pkg::uart_word_t  wdata1,
    input  wire                              wr0,
    input  wire                              wr1,
    output uart_path_pkg::client_vec_t       grant,
    output uart_frame_pkg::uart_word_t       wdata,
    output logic                             wr
);
    import uart_path_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT0,
        ARB_GRANT1
    } arb_state_t;

    arb_state_t  state;
    arb_state_t  state_next;
    client_vec_t grant_next;

    // only hand out the path once the tx fifo has drained
    // client 0 wins a tie
    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (tx_empty && req[0])
                    state_next = ARB_GRANT0;
                else if (tx_empty && req[1])
                    state_next = ARB_GRANT1;
            end
            // hold until the owner lets go of req
            ARB_GRANT0: if (!req[0]) state_next = ARB_IDLE;
            ARB_GRANT1: if (!req[1]) state_next = ARB_IDLE;
            default:    state_next = ARB_IDLE;
        endcase
    end

    // grant decoded from the registered state
    always_comb begin
        case (state)
            ARB_GRANT0: grant_next = 2'b01;
            ARB_GRANT1: grant_next = 2'b10;
            default:    grant_next = 2'b00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            grant <= '0;
        end else begin
            state <= state_next;
            grant <= grant_next;
        end
    end

    // write port mux, nothing passes without a grant
    always_comb begin
        case (grant)
            2'b01: begin
                wdata = wdata0;
                wr    = wr0;
            end
            2'b10: begin
                wdata = wdata1;
                wr    = wr1;
            end
            default: begin
                wdata = '0;
                wr    = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== uart_core.f ====
src/uart_frame_pkg.sv
src/uart_path_pkg.sv
src/uart_tx_arbiter.sv
src/uart_fifo.sv
src/baud_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_core.sv
verif/tb_clk_gen.sv
verif/tb_uart_core.sv

// ==== verif/tb_clk_gen.sv ====
// testbench clock source
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial clk = 1'b0;

    // free running, even duty cycle
    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== verif/tb_uart_core.sv ====
// uart core testbench
`default_nettype none
`timescale 1ns/1ps

module tb_uart_core;
    import uart_frame_pkg::*;
    import uart_path_pkg::*;

    localparam int DRIVE_DLY = 10;
    // prescale 0 gives one tick per clock and 8 clocks per bit
    localparam int BIT_CLKS = 8;
    localparam int FRAME_CLKS = 14 * BIT_CLKS;
    localparam int NUM_ROWS = 12;
    // table rows, burst frames and a few spare frames for arbitration
    localparam int WATCHDOG_NS = (NUM_ROWS + 16 + 6) * FRAME_CLKS * 100 + 500 * 100;

    localparam int WAIT_RX = 0;
    localparam int WAIT_TX_IDLE = 1;
    localparam int WAIT_GRANT0 = 2;
    localparam int WAIT_GRANT1 = 3;
    localparam int WAIT_RX_FULL = 4;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_PARITY,
        FAULT_STOP
    } fault_t;

    // one stimulus row and what the reader should see
    typedef struct packed {
        logic         client;
        uart_word_t   word;
        parity_mode_t pmode;
        logic         two_stop;
        logic         ext;
        fault_t       fault;
        uart_word_t   exp_rdata;
        int           exp_perr;
        int           exp_ferr;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         en;
    prescale_t    prescale;
    parity_mode_t parity_mode;
    logic         two_stop;
    logic         loopback_en;
    client_vec_t  req;
    uart_word_t   wdata0;
    logic         wr0;
    uart_word_t   wdata1;
    logic         wr1;
    logic         rd;
    logic         rx;
    client_vec_t  grant;
    logic         tx_empty;
    logic         tx_full;
    uart_word_t   rdata;
    logic         rx_empty;
    logic         rx_full;
    logic         parity_error;
    logic         frame_error;
    logic         tx;

    row_t       rows [NUM_ROWS];
    uart_word_t burst [17];
    int         seed;
    int         val_errs;
    int         other_errs;
    int         perr_cnt;
    int         ferr_cnt;

    tb_clk_gen #(.PERIOD(100)) u_clk_gen (.clk(clk));

    uart_core UUT (.*);

    // error pulses sampled mid cycle
    always @(negedge clk) begin
        if (parity_error)
            perr_cnt++;
        if (frame_error)
            ferr_cnt++;
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_value(input string name, input int exp, input int act);
        val_errs++;
        $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    // even parity makes the ones count even and odd inverts it
    function automatic logic parity_of(input uart_word_t w, input parity_mode_t m);
        return (^w) ^ (m == PARITY_ODD);
    endfunction

    function automatic uart_word_t rand_word();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic row_t make_row(input logic client, input uart_word_t word,
                                      input parity_mode_t pmode, input logic two,
                                      input logic ext, input fault_t fault);
        row_t r;
        r.client = client;
        r.word = word;
        r.pmode = pmode;
        r.two_stop = two;
        r.ext = ext;
        r.fault = fault;
        // word lands in the rx fifo even with a bad frame
        r.exp_rdata = word;
        r.exp_perr = (fault == FAULT_PARITY) ? 1 : 0;
        r.exp_ferr = (fault == FAULT_STOP) ? 1 : 0;
        return r;
    endfunction

    task automatic build_table();
        // loopback rows over every parity mode with one and two stop bits
        rows[0] = make_row(1'b0, 8'h55, PARITY_NONE, 1'b0, 1'b0, FAULT_NONE);
        rows[1] = make_row(1'b1, rand_word(), PARITY_ODD, 1'b0, 1'b0, FAULT_NONE);
        rows[2] = make_row(1'b0, rand_word(), PARITY_EVEN, 1'b1, 1'b0, FAULT_NONE);
        rows[3] = make_row(1'b1, 8'h00, PARITY_ODD, 1'b1, 1'b0, FAULT_NONE);
        rows[4] = make_row(1'b0, 8'hff, PARITY_EVEN, 1'b0, 1'b0, FAULT_NONE);
        rows[5] = make_row(1'b1, rand_word(), PARITY_NONE, 1'b1, 1'b0, FAULT_NONE);
        // frames bit-banged onto rx
        rows[6] = make_row(1'b0, rand_word(), PARITY_NONE, 1'b0, 1'b1, FAULT_NONE);
        rows[7] = make_row(1'b0, rand_word(), PARITY_EVEN, 1'b1, 1'b1, FAULT_NONE);
        rows[8] = make_row(1'b0, rand_word(), PARITY_ODD, 1'b0, 1'b1, FAULT_PARITY);
        rows[9] = make_row(1'b0, rand_word(), PARITY_EVEN, 1'b1, 1'b1, FAULT_PARITY);
        rows[10] = make_row(1'b0, rand_word(), PARITY_NONE, 1'b0, 1'b1, FAULT_STOP);
        rows[11] = make_row(1'b0, rand_word(), PARITY_ODD, 1'b1, 1'b1, FAULT_STOP);
    endtask

    function automatic logic cond_met(input int what);
        case (what)
            WAIT_RX:      return !rx_empty;
            WAIT_TX_IDLE: return tx_empty;
            WAIT_GRANT0:  return grant[0];
            WAIT_RX_FULL: return rx_full;
            default:      return grant[1];
        endcase
    endfunction

    function automatic string cond_name(input int what);
        case (what)
            WAIT_RX:      return "a word on rdata";
            WAIT_TX_IDLE: return "the tx fifo to drain";
            WAIT_GRANT0:  return "a grant for client 0";
            WAIT_RX_FULL: return "a full rx fifo";
            default:      return "a grant for client 1";
        endcase
    endfunction

    task automatic wait_for(input int what, input int limit);
        int n;
        n = 0;
        while (!cond_met(what) && n < limit) begin
            next_cycle();
            n++;
        end
        if (!cond_met(what)) begin
            other_errs++;
            $display("timeout at %0t ns: no sign of %s within %0d cycles",
                     $time, cond_name(what), limit);
        end
    endtask

    // request, wait for the grant, one write, let go
    task automatic write_word(input logic client, input uart_word_t word);
        req[client] = 1'b1;
        wait_for(client ? WAIT_GRANT1 : WAIT_GRANT0, 4 * FRAME_CLKS);
        if (client) begin
            wdata1 = word;
            wr1 = 1'b1;
        end else begin
            wdata0 = word;
            wr0 = 1'b1;
        end
        next_cycle();
        wr0 = 1'b0;
        wr1 = 1'b0;
        req = 2'b00;
    endtask

    task automatic send_bit(input logic b);
        rx = b;
        repeat (BIT_CLKS) next_cycle();
    endtask

    task automatic send_frame(input uart_word_t word, input parity_mode_t pmode,
                              input logic two, input fault_t fault);
        logic par;
        par = parity_of(word, pmode);
        if (fault == FAULT_PARITY)
            par = !par;
        send_bit(1'b0);
        // lsb first
        for (int i = 0; i < 8; i++)
            send_bit(word[i]);
        if (pmode != PARITY_NONE)
            send_bit(par);
        // fault lands on the first stop bit
        send_bit(fault != FAULT_STOP);
        if (two)
            send_bit(1'b1);
        rx = 1'b1;
    endtask

    task automatic pop_word();
        rd = 1'b1;
        next_cycle();
        rd = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int p0;
        int f0;
        // format only changes with both machines idle
        wait_for(WAIT_TX_IDLE, FRAME_CLKS);
        parity_mode = r.pmode;
        two_stop = r.two_stop;
        loopback_en = !r.ext;
        repeat (2 * BIT_CLKS) next_cycle();
        p0 = perr_cnt;
        f0 = ferr_cnt;
        if (r.ext)
            send_frame(r.word, r.pmode, r.two_stop, r.fault);
        else
            write_word(r.client, r.word);
        wait_for(WAIT_RX, 2 * FRAME_CLKS);
        if (!rx_empty) begin
            if (rdata !== r.exp_rdata)
                report_value("rdata", int'(r.exp_rdata), int'(rdata));
            pop_word();
            if (rx_empty !== 1'b1)
                report_value("rx_empty", 1, int'(rx_empty));
        end
        // tx still owes the tail of its stop bit
        wait_for(WAIT_TX_IDLE, FRAME_CLKS);
        if (perr_cnt - p0 != r.exp_perr)
            report_value("parity_error pulses", r.exp_perr, perr_cnt - p0);
        if (ferr_cnt - f0 != r.exp_ferr)
            report_value("frame_error pulses", r.exp_ferr, ferr_cnt - f0);
    endtask

    task automatic check_arbitration();
        parity_mode = PARITY_NONE;
        two_stop = 1'b0;
        loopback_en = 1'b1;
        // on a tie client 0 should win
        req = 2'b11;
        next_cycle();
        if (grant !== 2'b00)
            report_value("grant", 0, int'(grant));
        next_cycle();
        if (grant !== 2'b01)
            report_value("grant", 1, int'(grant));
        // stray write from the client without a grant
        wdata1 = 8'h3c;
        wr1 = 1'b1;
        next_cycle();
        wr1 = 1'b0;
        next_cycle();
        if (tx_empty !== 1'b1)
            report_value("tx_empty", 1, int'(tx_empty));
        req = 2'b10;
        repeat (2) next_cycle();
        if (grant !== 2'b00)
            report_value("grant", 0, int'(grant));
        next_cycle();
        if (grant !== 2'b10)
            report_value("grant", 2, int'(grant));
        req = 2'b00;
        repeat (2) next_cycle();
        if (grant !== 2'b00)
            report_value("grant", 0, int'(grant));
        // a leaked frame would have looped back by now
        repeat (FRAME_CLKS) next_cycle();
        if (rx_empty !== 1'b1)
            report_value("rx_empty", 1, int'(rx_empty));
    endtask

    task automatic check_burst();
        repeat (2 * BIT_CLKS) next_cycle();
        parity_mode = PARITY_EVEN;
        two_stop = 1'b0;
        loopback_en = 1'b1;
        for (int i = 0; i < 17; i++)
            burst[i] = rand_word();
        req = 2'b01;
        wait_for(WAIT_GRANT0, FRAME_CLKS);
        // back to back writes far faster than the line drains
        for (int i = 0; i < 16; i++) begin
            wdata0 = burst[i];
            wr0 = 1'b1;
            next_cycle();
        end
        wr0 = 1'b0;
        if (tx_full !== 1'b1)
            report_value("tx_full", 1, int'(tx_full));
        // fifo is full so this one is lost
        wdata0 = burst[16];
        wr0 = 1'b1;
        next_cycle();
        wr0 = 1'b0;
        req = 2'b00;
        // nothing popped yet so all sixteen pile up in the rx fifo
        wait_for(WAIT_RX_FULL, 20 * FRAME_CLKS);
        for (int i = 0; i < 16; i++) begin
            if (rdata !== burst[i])
                report_value("rdata", int'(burst[i]), int'(rdata));
            pop_word();
            if (rx_full !== 1'b0)
                report_value("rx_full", 0, int'(rx_full));
        end
        repeat (2 * FRAME_CLKS) next_cycle();
        if (rx_empty !== 1'b1)
            report_value("rx_empty", 1, int'(rx_empty));
    endtask

    initial begin
        seed = 11;
        val_errs = 0;
        other_errs = 0;
        perr_cnt = 0;
        ferr_cnt = 0;
        rst_n = 1'b0;
        en = 1'b1;
        prescale = '0;
        parity_mode = PARITY_NONE;
        two_stop = 1'b0;
        loopback_en = 1'b1;
        req = 2'b00;
        wdata0 = '0;
        wr0 = 1'b0;
        wdata1 = '0;
        wr1 = 1'b0;
        rd = 1'b0;
        rx = 1'b1;
        build_table();
        repeat (5) @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;
        // idle state out of reset
        if (tx !== 1'b1)
            report_value("tx", 1, int'(tx));
        if (grant !== 2'b00)
            report_value("grant", 0, int'(grant));
        if (tx_empty !== 1'b1)
            report_value("tx_empty", 1, int'(tx_empty));
        if (rx_empty !== 1'b1)
            report_value("rx_empty", 1, int'(rx_empty));
        if (parity_error !== 1'b0 || frame_error !== 1'b0)
            report_value("error flags", 0, int'({parity_error, frame_error}));
        check_arbitration();
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(rows[i]);
        check_burst();
        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // hard stop if the run stalls
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns, the run did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
